// File: hw/raster_fixed_pkg.sv
//----------------------------------------------------------
// Fixed-point defaults and the MSAA sample-grid encoding
// used by the bounding-box stage. Coordinates are signed,
// with RADIX fraction bits below the integer part.
// Import where a module needs the mode values.
//----------------------------------------------------------
package raster_fixed_pkg;

    // Default coordinate width and fraction bits
    parameter int DEF_SIGFIG = 24;
    parameter int DEF_RADIX  = 10;

    // Sample grid select, one-hot
    // Each finer grid keeps one more top fraction bit
    typedef enum logic [3:0] {
        MSAA_1X  = 4'b1000, // Whole pixels, no fraction kept
        MSAA_4X  = 4'b0100, // Half-pixel pitch
        MSAA_16X = 4'b0010, // Quarter-pixel pitch
        MSAA_64X = 4'b0001  // Eighth-pixel pitch
    } msaa_e;

endpackage

// File: hw/raster_geom_pkg.sv
//----------------------------------------------------------
// Triangle and box geometry counts and index names.
// Box arrays are indexed [corner][axis], vertex arrays
// by vertex number.
//----------------------------------------------------------
package raster_geom_pkg;

    // Vertices per triangle
    parameter int NUM_VERTS = 3;

    // Box corners, lower-left and upper-right
    parameter int NUM_CORNERS = 2;
    parameter int CORNER_LL   = 0;
    parameter int CORNER_UR   = 1;

    // Coordinate axes
    parameter int AXIS_X = 0;
    parameter int AXIS_Y = 1;

endpackage

// File: hw/bbox_extent.sv
//----------------------------------------------------------
// Raw bounding box of one triangle, plus the backface test.
// Purely combinational; the box corners are picked from the
// vertices by one-hot selects built from pairwise compares.
//----------------------------------------------------------
`timescale 1ns/1ps

module bbox_extent #(
    parameter int SIGFIG = raster_fixed_pkg::DEF_SIGFIG
) (
    input  logic signed [SIGFIG-1:0] tri_x [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] tri_y [raster_geom_pkg::NUM_VERTS],
    output logic signed [SIGFIG-1:0] raw_ll_x,
    output logic signed [SIGFIG-1:0] raw_ll_y,
    output logic signed [SIGFIG-1:0] raw_ur_x,
    output logic signed [SIGFIG-1:0] raw_ur_y,
    output logic                     backface
);
    import raster_geom_pkg::*;

    // Vertex coordinates regrouped by axis
    logic signed [SIGFIG-1:0] vert [AXIS_X:AXIS_Y][NUM_VERTS];
    // One-hot vertex select per corner and axis
    logic [NUM_VERTS-1:0]     sel  [NUM_CORNERS][AXIS_X:AXIS_Y];
    logic signed [SIGFIG-1:0] box  [NUM_CORNERS][AXIS_X:AXIS_Y];
    // Edge deltas, one bit wider than a coordinate
    logic signed [SIGFIG:0]     dx10;
    logic signed [SIGFIG:0]     dx21;
    logic signed [SIGFIG:0]     dy10;
    logic signed [SIGFIG:0]     dy21;
    // Cross terms at double width
    logic signed [2*SIGFIG+1:0] cross_l;
    logic signed [2*SIGFIG+1:0] cross_r;

    assign vert[AXIS_X] = tri_x;
    assign vert[AXIS_Y] = tri_y;

    always_comb begin
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            // Minimum, ties go to the lower vertex index
            sel[CORNER_LL][a][0] = (vert[a][0] <= vert[a][1]) && (vert[a][0] <= vert[a][2]);
            sel[CORNER_LL][a][1] = (vert[a][1] <  vert[a][0]) && (vert[a][1] <= vert[a][2]);
            sel[CORNER_LL][a][2] = (vert[a][2] <  vert[a][0]) && (vert[a][2] <  vert[a][1]);
            // Maximum, same tie rule
            sel[CORNER_UR][a][0] = (vert[a][0] >= vert[a][1]) && (vert[a][0] >= vert[a][2]);
            sel[CORNER_UR][a][1] = (vert[a][1] >  vert[a][0]) && (vert[a][1] >= vert[a][2]);
            sel[CORNER_UR][a][2] = (vert[a][2] >  vert[a][0]) && (vert[a][2] >  vert[a][1]);
        end
        // Mux each corner coordinate from its select
        for (int c = 0; c < NUM_CORNERS; c++) begin
            for (int a = AXIS_X; a <= AXIS_Y; a++) begin
                box[c][a] = vert[a][0];
                for (int v = 1; v < NUM_VERTS; v++) begin
                    if (sel[c][a][v]) box[c][a] = vert[a][v];
                end
                assert final ($onehot(sel[c][a]));
            end
        end
        // Ordered box regardless of vertex order
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            assert final (box[CORNER_LL][a] <= box[CORNER_UR][a]);
        end
    end

    assign raw_ll_x = box[CORNER_LL][AXIS_X];
    assign raw_ll_y = box[CORNER_LL][AXIS_Y];
    assign raw_ur_x = box[CORNER_UR][AXIS_X];
    assign raw_ur_y = box[CORNER_UR][AXIS_Y];

    // Winding test: backward when (x1-x0)(y2-y1) > (x2-x1)(y1-y0)
    assign dx10     = tri_x[1] - tri_x[0];
    assign dx21     = tri_x[2] - tri_x[1];
    assign dy10     = tri_y[1] - tri_y[0];
    assign dy21     = tri_y[2] - tri_y[1];
    assign cross_l  = dx10 * dy21;
    assign cross_r  = dx21 * dy10;
    assign backface = cross_l > cross_r;

endmodule

// File: hw/subsample_floor.sv
//----------------------------------------------------------
// Floors the four raw box coordinates to the sample grid
// chosen by the MSAA mode. Integer bits pass unchanged;
// fraction bits below the sample pitch are cleared.
//----------------------------------------------------------
`timescale 1ns/1ps

module subsample_floor #(
    parameter int SIGFIG = raster_fixed_pkg::DEF_SIGFIG,
    parameter int RADIX  = raster_fixed_pkg::DEF_RADIX
) (
    input  logic signed [SIGFIG-1:0] raw_ll_x,
    input  logic signed [SIGFIG-1:0] raw_ll_y,
    input  logic signed [SIGFIG-1:0] raw_ur_x,
    input  logic signed [SIGFIG-1:0] raw_ur_y,
    input  raster_fixed_pkg::msaa_e  msaa_mode,
    output logic signed [SIGFIG-1:0] flr_ll_x,
    output logic signed [SIGFIG-1:0] flr_ll_y,
    output logic signed [SIGFIG-1:0] flr_ur_x,
    output logic signed [SIGFIG-1:0] flr_ur_y
);
    import raster_fixed_pkg::*;
    import raster_geom_pkg::*;

    logic signed [SIGFIG-1:0] raw [NUM_CORNERS][AXIS_X:AXIS_Y];
    logic signed [SIGFIG-1:0] flr [NUM_CORNERS][AXIS_X:AXIS_Y];
    // Sample pitch in LSBs and the mask that keeps bits above it
    logic signed [SIGFIG-1:0] pitch;
    logic signed [SIGFIG-1:0] keep_mask;

    always_comb begin
        case (msaa_mode)
            MSAA_4X:  pitch = SIGFIG'(1) << (RADIX - 1);
            MSAA_16X: pitch = SIGFIG'(1) << (RADIX - 2);
            MSAA_64X: pitch = SIGFIG'(1) << (RADIX - 3);
            default:  pitch = SIGFIG'(1) << RADIX;
        endcase
        keep_mask = ~(pitch - SIGFIG'(1));
    end

    assign raw[CORNER_LL][AXIS_X] = raw_ll_x;
    assign raw[CORNER_LL][AXIS_Y] = raw_ll_y;
    assign raw[CORNER_UR][AXIS_X] = raw_ur_x;
    assign raw[CORNER_UR][AXIS_Y] = raw_ur_y;

    for (genvar c = 0; c < NUM_CORNERS; c++) begin : g_corner
        for (genvar a = AXIS_X; a <= AXIS_Y; a++) begin : g_axis
            // Two's complement masking floors toward minus infinity
            assign flr[c][a] = raw[c][a] & keep_mask;

            always_comb begin
                assert final ((flr[c][a] <= raw[c][a]) && (raw[c][a] - flr[c][a] < pitch));
            end
        end
    end

    assign flr_ll_x = flr[CORNER_LL][AXIS_X];
    assign flr_ll_y = flr[CORNER_LL][AXIS_Y];
    assign flr_ur_x = flr[CORNER_UR][AXIS_X];
    assign flr_ur_y = flr[CORNER_UR][AXIS_Y];

endmodule

// File: hw/screen_clip.sv
//----------------------------------------------------------
// Clamps the floored box to the screen and forms the valid
// that enters the pipe. Culled, backward and off-screen
// triangles leave here as bubbles.
//----------------------------------------------------------
`timescale 1ns/1ps

module screen_clip #(
    parameter int SIGFIG = raster_fixed_pkg::DEF_SIGFIG
) (
    input  logic signed [SIGFIG-1:0] raw_ll_x,
    input  logic signed [SIGFIG-1:0] raw_ll_y,
    input  logic signed [SIGFIG-1:0] raw_ur_x,
    input  logic signed [SIGFIG-1:0] raw_ur_y,
    input  logic signed [SIGFIG-1:0] flr_ll_x,
    input  logic signed [SIGFIG-1:0] flr_ll_y,
    input  logic signed [SIGFIG-1:0] flr_ur_x,
    input  logic signed [SIGFIG-1:0] flr_ur_y,
    input  logic signed [SIGFIG-1:0] screen_x,
    input  logic signed [SIGFIG-1:0] screen_y,
    input  logic                     tri_valid,
    input  logic                     backface,
    output logic signed [SIGFIG-1:0] clp_ll_x,
    output logic signed [SIGFIG-1:0] clp_ll_y,
    output logic signed [SIGFIG-1:0] clp_ur_x,
    output logic signed [SIGFIG-1:0] clp_ur_y,
    output logic                     entry_valid
);
    import raster_geom_pkg::*;

    logic signed [SIGFIG-1:0] raw [NUM_CORNERS][AXIS_X:AXIS_Y];
    logic signed [SIGFIG-1:0] flr [NUM_CORNERS][AXIS_X:AXIS_Y];
    logic signed [SIGFIG-1:0] clp [NUM_CORNERS][AXIS_X:AXIS_Y];
    logic signed [SIGFIG-1:0] lim [AXIS_X:AXIS_Y];
    // Box wholly outside the screen on this axis
    logic                     off_axis [AXIS_X:AXIS_Y];

    assign raw[CORNER_LL] = '{raw_ll_x, raw_ll_y};
    assign raw[CORNER_UR] = '{raw_ur_x, raw_ur_y};
    assign flr[CORNER_LL] = '{flr_ll_x, flr_ll_y};
    assign flr[CORNER_UR] = '{flr_ur_x, flr_ur_y};
    assign lim            = '{screen_x, screen_y};

    always_comb begin
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            // Decide the clamp on the raw value, keep the floored one otherwise
            clp[CORNER_LL][a] = (raw[CORNER_LL][a] < 0) ? '0 : flr[CORNER_LL][a];
            clp[CORNER_UR][a] = (raw[CORNER_UR][a] > lim[a]) ? lim[a] : flr[CORNER_UR][a];
            off_axis[a] = (flr[CORNER_UR][a] < 0) || (flr[CORNER_LL][a] > lim[a]);
        end
        entry_valid = tri_valid && !backface && !off_axis[AXIS_X] && !off_axis[AXIS_Y];
        // A box that enters the pipe lies on the screen
        for (int a = AXIS_X; a <= AXIS_Y; a++) begin
            assert final (!entry_valid || ((clp[CORNER_LL][a] >= 0) && (clp[CORNER_UR][a] <= lim[a])));
        end
    end

    assign clp_ll_x = clp[CORNER_LL][AXIS_X];
    assign clp_ll_y = clp[CORNER_LL][AXIS_Y];
    assign clp_ur_x = clp[CORNER_UR][AXIS_X];
    assign clp_ur_y = clp[CORNER_UR][AXIS_Y];

endmodule

// File: hw/bbox_stall_pipe.sv
//----------------------------------------------------------
// PIPE_DEPTH-deep register chain for vertices, clipped box
// and valid. One shared enable: the chain advances when the
// next stage is free or the output holds a bubble.
//----------------------------------------------------------
`timescale 1ns/1ps

module bbox_stall_pipe #(
    parameter int SIGFIG     = raster_fixed_pkg::DEF_SIGFIG,
    parameter int PIPE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     halt_n,
    input  logic signed [SIGFIG-1:0] tri_x [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] tri_y [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] clp_ll_x,
    input  logic signed [SIGFIG-1:0] clp_ll_y,
    input  logic signed [SIGFIG-1:0] clp_ur_x,
    input  logic signed [SIGFIG-1:0] clp_ur_y,
    input  logic                     entry_valid,
    output logic signed [SIGFIG-1:0] out_tri_x [raster_geom_pkg::NUM_VERTS],
    output logic signed [SIGFIG-1:0] out_tri_y [raster_geom_pkg::NUM_VERTS],
    output logic signed [SIGFIG-1:0] box_ll_x,
    output logic signed [SIGFIG-1:0] box_ll_y,
    output logic signed [SIGFIG-1:0] box_ur_x,
    output logic signed [SIGFIG-1:0] box_ur_y,
    output logic                     out_valid
);
    import raster_geom_pkg::*;

    // Stage 0 is nearest the input
    logic signed [SIGFIG-1:0] st_x   [PIPE_DEPTH][NUM_VERTS];
    logic signed [SIGFIG-1:0] st_y   [PIPE_DEPTH][NUM_VERTS];
    logic signed [SIGFIG-1:0] st_box [PIPE_DEPTH][NUM_CORNERS][AXIS_X:AXIS_Y];
    logic [PIPE_DEPTH-1:0]    st_valid;
    logic                     advance;

    // Move on when downstream takes data, or squeeze out an output bubble
    assign advance = halt_n || !out_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st_valid <= '0;
            for (int s = 0; s < PIPE_DEPTH; s++) begin
                for (int v = 0; v < NUM_VERTS; v++) begin
                    st_x[s][v] <= '0;
                    st_y[s][v] <= '0;
                end
                for (int c = 0; c < NUM_CORNERS; c++) begin
                    for (int a = AXIS_X; a <= AXIS_Y; a++) begin
                        st_box[s][c][a] <= '0;
                    end
                end
            end
        end else if (advance) begin
            st_valid[0] <= entry_valid;
            st_x[0]     <= tri_x;
            st_y[0]     <= tri_y;
            st_box[0]   <= '{'{clp_ll_x, clp_ll_y}, '{clp_ur_x, clp_ur_y}};
            for (int s = 1; s < PIPE_DEPTH; s++) begin
                st_valid[s] <= st_valid[s-1];
                st_x[s]     <= st_x[s-1];
                st_y[s]     <= st_y[s-1];
                st_box[s]   <= st_box[s-1];
            end
        end
    end

    assign out_tri_x = st_x[PIPE_DEPTH-1];
    assign out_tri_y = st_y[PIPE_DEPTH-1];
    assign box_ll_x  = st_box[PIPE_DEPTH-1][CORNER_LL][AXIS_X];
    assign box_ll_y  = st_box[PIPE_DEPTH-1][CORNER_LL][AXIS_Y];
    assign box_ur_x  = st_box[PIPE_DEPTH-1][CORNER_UR][AXIS_X];
    assign box_ur_y  = st_box[PIPE_DEPTH-1][CORNER_UR][AXIS_Y];
    assign out_valid = st_valid[PIPE_DEPTH-1];

    // Delivered boxes stay ordered after floor and clamp
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> (box_ll_x <= box_ur_x) && (box_ll_y <= box_ur_y));

    // Held output does not move while the next stage is busy
    assert property (@(posedge clk) disable iff (!arst_n)
        (!halt_n && out_valid) |=> $stable({box_ll_x, box_ll_y, box_ur_x, box_ur_y, out_valid}));

    for (genvar v = 0; v < NUM_VERTS; v++) begin : g_hold_vert
        assert property (@(posedge clk) disable iff (!arst_n)
            (!halt_n && out_valid) |=> $stable(out_tri_x[v]) && $stable(out_tri_y[v]));
    end

endmodule

// File: hw/bbox_raster.sv
//----------------------------------------------------------
// Bounding-box stage top level. Extent, sample floor and
// screen clip work in the entry cycle; the stall pipe adds
// PIPE_DEPTH register stages. Set parameters here only.
//----------------------------------------------------------
`timescale 1ns/1ps

module bbox_raster #(
    parameter int SIGFIG     = raster_fixed_pkg::DEF_SIGFIG,
    parameter int RADIX      = raster_fixed_pkg::DEF_RADIX,
    parameter int PIPE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic signed [SIGFIG-1:0] tri_x [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] tri_y [raster_geom_pkg::NUM_VERTS],
    input  logic                     tri_valid,
    input  logic                     halt_n,
    input  logic signed [SIGFIG-1:0] screen_x,
    input  logic signed [SIGFIG-1:0] screen_y,
    input  raster_fixed_pkg::msaa_e  msaa_mode,
    output logic signed [SIGFIG-1:0] out_tri_x [raster_geom_pkg::NUM_VERTS],
    output logic signed [SIGFIG-1:0] out_tri_y [raster_geom_pkg::NUM_VERTS],
    output logic signed [SIGFIG-1:0] box_ll_x,
    output logic signed [SIGFIG-1:0] box_ll_y,
    output logic signed [SIGFIG-1:0] box_ur_x,
    output logic signed [SIGFIG-1:0] box_ur_y,
    output logic                     out_valid
);

    // Raw min/max box and winding
    logic signed [SIGFIG-1:0] raw_ll_x, raw_ll_y, raw_ur_x, raw_ur_y;
    logic                     backface;
    // Box on the sample grid
    logic signed [SIGFIG-1:0] flr_ll_x, flr_ll_y, flr_ur_x, flr_ur_y;
    // Box on the screen, with the valid entering the pipe
    logic signed [SIGFIG-1:0] clp_ll_x, clp_ll_y, clp_ur_x, clp_ur_y;
    logic                     entry_valid;

    bbox_extent #(.SIGFIG(SIGFIG)) extent_i (
        .tri_x    (tri_x),
        .tri_y    (tri_y),
        .raw_ll_x (raw_ll_x),
        .raw_ll_y (raw_ll_y),
        .raw_ur_x (raw_ur_x),
        .raw_ur_y (raw_ur_y),
        .backface (backface)
    );

    subsample_floor #(.SIGFIG(SIGFIG), .RADIX(RADIX)) floor_i (
        .raw_ll_x  (raw_ll_x),
        .raw_ll_y  (raw_ll_y),
        .raw_ur_x  (raw_ur_x),
        .raw_ur_y  (raw_ur_y),
        .msaa_mode (msaa_mode),
        .flr_ll_x  (flr_ll_x),
        .flr_ll_y  (flr_ll_y),
        .flr_ur_x  (flr_ur_x),
        .flr_ur_y  (flr_ur_y)
    );

    screen_clip #(.SIGFIG(SIGFIG)) clip_i (
        .raw_ll_x    (raw_ll_x),
        .raw_ll_y    (raw_ll_y),
        .raw_ur_x    (raw_ur_x),
        .raw_ur_y    (raw_ur_y),
        .flr_ll_x    (flr_ll_x),
        .flr_ll_y    (flr_ll_y),
        .flr_ur_x    (flr_ur_x),
        .flr_ur_y    (flr_ur_y),
        .screen_x    (screen_x),
        .screen_y    (screen_y),
        .tri_valid   (tri_valid),
        .backface    (backface),
        .clp_ll_x    (clp_ll_x),
        .clp_ll_y    (clp_ll_y),
        .clp_ur_x    (clp_ur_x),
        .clp_ur_y    (clp_ur_y),
        .entry_valid (entry_valid)
    );

    bbox_stall_pipe #(.SIGFIG(SIGFIG), .PIPE_DEPTH(PIPE_DEPTH)) pipe_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .halt_n      (halt_n),
        .tri_x       (tri_x),
        .tri_y       (tri_y),
        .clp_ll_x    (clp_ll_x),
        .clp_ll_y    (clp_ll_y),
        .clp_ur_x    (clp_ur_x),
        .clp_ur_y    (clp_ur_y),
        .entry_valid (entry_valid),
        .out_tri_x   (out_tri_x),
        .out_tri_y   (out_tri_y),
        .box_ll_x    (box_ll_x),
        .box_ll_y    (box_ll_y),
        .box_ur_x    (box_ur_x),
        .box_ur_y    (box_ur_y),
        .out_valid   (out_valid)
    );

endmodule

// File: verif/bbox_checker.sv
//----------------------------------------------------------
// Scoreboard for the bounding-box stage. The driver pushes
// an expected box when a triangle is taken; each output the
// next stage consumes is popped in order and compared.
// Also watches that a halted output does not move.
//----------------------------------------------------------
`timescale 1ns/1ps

module bbox_checker #(
    parameter int SIGFIG     = raster_fixed_pkg::DEF_SIGFIG,
    parameter int PIPE_DEPTH = 3
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     halt_n,
    // Expected entry, captured at the edge where push is high
    input  logic                     push,
    input  logic                     push_lat,
    input  logic [8*12-1:0]          push_name,
    input  logic signed [SIGFIG-1:0] push_box [4],
    input  logic signed [SIGFIG-1:0] tri_x [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] tri_y [raster_geom_pkg::NUM_VERTS],
    // DUT outputs
    input  logic signed [SIGFIG-1:0] out_tri_x [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] out_tri_y [raster_geom_pkg::NUM_VERTS],
    input  logic signed [SIGFIG-1:0] box_ll_x,
    input  logic signed [SIGFIG-1:0] box_ll_y,
    input  logic signed [SIGFIG-1:0] box_ur_x,
    input  logic signed [SIGFIG-1:0] box_ur_y,
    input  logic                     out_valid,
    output int                       pass_cnt,
    output int                       fail_cnt,
    output int                       pending
);
    import raster_geom_pkg::*;

    // Box packed as ll_x, ll_y, ur_x, ur_y from the top slice down
    typedef logic [3:0][SIGFIG-1:0] box_t;

    typedef struct packed {
        logic [8*12-1:0]                  name;
        box_t                             box;
        logic [NUM_VERTS-1:0][SIGFIG-1:0] vx;
        logic [NUM_VERTS-1:0][SIGFIG-1:0] vy;
        int                               take;
        logic                             lat;
    } exp_t;

    exp_t exp_q [$];
    exp_t cur;
    exp_t nxt;
    // Present output, and its copy from a halted edge
    exp_t got;
    exp_t snap;
    logic held;
    logic ok;
    int   edge_cnt;

    function automatic string show_box(input box_t b);
        return $sformatf("(%0d,%0d)-(%0d,%0d)", $signed(b[3]), $signed(b[2]),
                         $signed(b[1]), $signed(b[0]));
    endfunction

    always_comb begin
        got     = '0;
        got.box = {box_ll_x, box_ll_y, box_ur_x, box_ur_y};
        for (int v = 0; v < NUM_VERTS; v++) begin
            got.vx[v] = out_tri_x[v];
            got.vy[v] = out_tri_y[v];
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            pass_cnt = 0;
            fail_cnt = 0;
            pending  = 0;
            edge_cnt = 0;
            held     = 1'b0;
        end else begin
            // Output held by the next stage must stay put
            if (held && (!out_valid || got != snap)) begin
                $display("MISMATCH at %0t: output moved while the next stage was halted", $time);
                fail_cnt++;
            end
            held = out_valid && !halt_n;
            snap = got;
            // Consumed output
            if (out_valid && halt_n) begin
                if (exp_q.size() == 0) begin
                    $display("Valid output at %0t arrived with no triangle expected", $time);
                    fail_cnt++;
                end else begin
                    cur = exp_q.pop_front();
                    ok  = 1'b1;
                    if (got.box != cur.box) begin
                        $display("MISMATCH at %0t: %s box %s, expected %s", $time, cur.name,
                                 show_box(got.box), show_box(cur.box));
                        ok = 1'b0;
                    end
                    if (got.vx != cur.vx || got.vy != cur.vy) begin
                        $display("MISMATCH at %0t: %s vertices differ from the input", $time,
                                 cur.name);
                        ok = 1'b0;
                    end
                    if (cur.lat && (edge_cnt - cur.take != PIPE_DEPTH)) begin
                        $display("MISMATCH at %0t: %s took %0d cycles, expected %0d", $time,
                                 cur.name, edge_cnt - cur.take, PIPE_DEPTH);
                        ok = 1'b0;
                    end
                    $display("test %s: %s", cur.name, ok ? "ok" : "failed");
                    if (ok) pass_cnt++;
                    else fail_cnt++;
                end
            end
            // New expectation, vertices as presented at the taking edge
            if (push) begin
                nxt      = '0;
                nxt.name = push_name;
                nxt.box  = {push_box[0], push_box[1], push_box[2], push_box[3]};
                for (int v = 0; v < NUM_VERTS; v++) begin
                    nxt.vx[v] = tri_x[v];
                    nxt.vy[v] = tri_y[v];
                end
                nxt.take = edge_cnt;
                nxt.lat  = push_lat;
                exp_q.push_back(nxt);
            end
            edge_cnt++;
            pending = exp_q.size();
        end
    end

endmodule

// File: verif/bbox_tb.sv
//----------------------------------------------------------
// Testbench for the bounding-box stage. A table of triangles
// with hand-worked boxes is driven on the falling edge, each
// held until the chain advances; the checker compares every
// delivered box. Run through the file list in the root.
//----------------------------------------------------------
`timescale 1ns/1ps

module bbox_tb;
    import raster_fixed_pkg::*;
    import raster_geom_pkg::*;

    localparam int SIGFIG     = DEF_SIGFIG;
    localparam int PIPE_DEPTH = 3;
    // Pixel size in coordinate LSBs and a 64 by 48 pixel screen
    localparam int P  = 1 << DEF_RADIX;
    localparam int SX = 64 * P;
    localparam int SY = 48 * P;
    // Fraction .90625 floors differently under every sample grid
    localparam int F  = 928;

    typedef struct {
        logic [8*12-1:0] name;
        int              vx [NUM_VERTS];
        int              vy [NUM_VERTS];
        msaa_e           mode;
        bit              rand_halt;
        bit              valid;
        int              box [4];
    } entry_t;

    logic                     clk;
    logic                     arst_n;
    logic signed [SIGFIG-1:0] tri_x [NUM_VERTS];
    logic signed [SIGFIG-1:0] tri_y [NUM_VERTS];
    logic                     tri_valid;
    logic                     halt_n;
    logic signed [SIGFIG-1:0] screen_x;
    logic signed [SIGFIG-1:0] screen_y;
    msaa_e                    msaa_mode;
    logic signed [SIGFIG-1:0] out_tri_x [NUM_VERTS];
    logic signed [SIGFIG-1:0] out_tri_y [NUM_VERTS];
    logic signed [SIGFIG-1:0] box_ll_x;
    logic signed [SIGFIG-1:0] box_ll_y;
    logic signed [SIGFIG-1:0] box_ur_x;
    logic signed [SIGFIG-1:0] box_ur_y;
    logic                     out_valid;
    // Expected entry handed to the checker
    logic                     push;
    logic                     push_lat;
    logic [8*12-1:0]          push_name;
    logic signed [SIGFIG-1:0] push_box [4];
    int                       pass_cnt;
    int                       fail_cnt;
    int                       pending;
    int                       tb_errs;
    int                       limit;
    entry_t                   tbl [$];

    bbox_raster #(.PIPE_DEPTH(PIPE_DEPTH)) dut_i (.*);

    bbox_checker #(.SIGFIG(SIGFIG), .PIPE_DEPTH(PIPE_DEPTH)) chk_i (.*);

    always #50 clk = ~clk;

    task automatic add_entry(input logic [8*12-1:0] name,
                             input int x0, input int y0, input int x1, input int y1,
                             input int x2, input int y2, input msaa_e mode,
                             input bit rand_halt, input bit valid,
                             input int llx, input int lly, input int urx, input int ury);
        entry_t e;
        e.name      = name;
        e.vx        = '{x0, x1, x2};
        e.vy        = '{y0, y1, y2};
        e.mode      = mode;
        e.rand_halt = rand_halt;
        e.valid     = valid;
        e.box       = '{llx, lly, urx, ury};
        tbl.push_back(e);
    endtask

    task automatic apply_entry(input int i);
        logic taken;
        int   idle;
        taken     = 1'b0;
        tri_x     = '{SIGFIG'(tbl[i].vx[0]), SIGFIG'(tbl[i].vx[1]), SIGFIG'(tbl[i].vx[2])};
        tri_y     = '{SIGFIG'(tbl[i].vy[0]), SIGFIG'(tbl[i].vy[1]), SIGFIG'(tbl[i].vy[2])};
        msaa_mode = tbl[i].mode;
        tri_valid = 1'b1;
        // Hold the triangle until an edge where the chain advances
        while (!taken) begin
            halt_n    = tbl[i].rand_halt ? 1'($urandom_range(1, 0)) : 1'b1;
            taken     = halt_n || !out_valid;
            push      = taken && tbl[i].valid;
            push_lat  = (i == 0);
            push_name = tbl[i].name;
            push_box  = '{SIGFIG'(tbl[i].box[0]), SIGFIG'(tbl[i].box[1]),
                          SIGFIG'(tbl[i].box[2]), SIGFIG'(tbl[i].box[3])};
            @(negedge clk);
        end
        push = 1'b0;
        if (!tbl[i].valid) $display("test %s: taken as a bubble", tbl[i].name);
        // Idle gap between triangles
        idle = $urandom_range(2, 0);
        repeat (idle) begin
            tri_valid = 1'b0;
            halt_n    = tbl[i].rand_halt ? 1'($urandom_range(1, 0)) : 1'b1;
            @(negedge clk);
        end
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        tri_x     = '{default: '0};
        tri_y     = '{default: '0};
        // A valid triangle waits at the input and must not enter during reset
        tri_valid = 1'b1;
        halt_n    = 1'b1;
        screen_x  = SIGFIG'(SX);
        screen_y  = SIGFIG'(SY);
        msaa_mode = MSAA_1X;
        push      = 1'b0;
        push_lat  = 1'b0;
        push_name = '0;
        push_box  = '{default: '0};
        tb_errs   = 0;
        void'($urandom(96));

        // Unordered vertices and then one shape under each sample grid
        add_entry("basic_1x", 20*P+256, 9*P+512, 5*P+768, 30*P, 40*P+512, 12*P+128,
                  MSAA_1X, 0, 1, 5*P, 9*P, 40*P, 30*P);
        add_entry("frac_1x", 3*P+F, 4*P+F, 7*P+F, 11*P+F, 12*P+F, 6*P+F,
                  MSAA_1X, 0, 1, 3*P, 4*P, 12*P, 11*P);
        add_entry("frac_4x", 3*P+F, 4*P+F, 7*P+F, 11*P+F, 12*P+F, 6*P+F,
                  MSAA_4X, 0, 1, 3*P+512, 4*P+512, 12*P+512, 11*P+512);
        add_entry("frac_16x", 3*P+F, 4*P+F, 7*P+F, 11*P+F, 12*P+F, 6*P+F,
                  MSAA_16X, 0, 1, 3*P+768, 4*P+768, 12*P+768, 11*P+768);
        add_entry("frac_64x", 3*P+F, 4*P+F, 7*P+F, 11*P+F, 12*P+F, 6*P+F,
                  MSAA_64X, 0, 1, 3*P+896, 4*P+896, 12*P+896, 11*P+896);
        // Clamped boxes and boxes wholly off the screen
        add_entry("clamp_zero", -2*P-512, 5*P, 4*P, 20*P, 10*P, -P-256,
                  MSAA_1X, 0, 1, 0, 0, 10*P, 20*P);
        add_entry("clamp_limit", 50*P, 40*P, 60*P, 55*P+256, 70*P+512, 44*P,
                  MSAA_1X, 0, 1, 50*P, 40*P, SX, SY);
        add_entry("beyond_scr", 70*P, 10*P, 75*P, 20*P, 80*P, 12*P,
                  MSAA_1X, 0, 0, 0, 0, 0, 0);
        add_entry("below_zero", -10*P, -9*P, -6*P, -2*P, -3*P, -7*P,
                  MSAA_1X, 0, 0, 0, 0, 0, 0);
        // Backward winding and the same shape with v1 and v2 swapped
        add_entry("backface", 2*P, 3*P, 10*P, 5*P, 6*P, 12*P,
                  MSAA_1X, 0, 0, 0, 0, 0, 0);
        add_entry("front_swap", 2*P, 3*P, 6*P, 12*P, 10*P, 5*P,
                  MSAA_1X, 0, 1, 2*P, 3*P, 10*P, 12*P);
        // Same shapes again under random halts
        add_entry("halt_basic", 20*P+256, 9*P+512, 5*P+768, 30*P, 40*P+512, 12*P+128,
                  MSAA_1X, 1, 1, 5*P, 9*P, 40*P, 30*P);
        add_entry("halt_16x", 3*P+F, 4*P+F, 7*P+F, 11*P+F, 12*P+F, 6*P+F,
                  MSAA_16X, 1, 1, 3*P+768, 4*P+768, 12*P+768, 11*P+768);
        add_entry("halt_back", 2*P, 3*P, 10*P, 5*P, 6*P, 12*P,
                  MSAA_1X, 1, 0, 0, 0, 0, 0);
        add_entry("halt_limit", 50*P, 40*P, 60*P, 55*P+256, 70*P+512, 44*P,
                  MSAA_1X, 1, 1, 50*P, 40*P, SX, SY);
        add_entry("halt_64x", 3*P+F, 4*P+F, 7*P+F, 11*P+F, 12*P+F, 6*P+F,
                  MSAA_64X, 1, 1, 3*P+896, 4*P+896, 12*P+896, 11*P+896);
        add_entry("halt_zero", -2*P-512, 5*P, 4*P, 20*P, 10*P, -P-256,
                  MSAA_1X, 1, 1, 0, 0, 10*P, 20*P);
        add_entry("halt_swap", 2*P, 3*P, 6*P, 12*P, 10*P, 5*P,
                  MSAA_1X, 1, 1, 2*P, 3*P, 10*P, 12*P);

        // Watchdog allows 40 periods per entry plus slack
        limit = tbl.size() * 40 + 20;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("Run timed out after %0d clock periods", limit);
                $display("Result: FAILED");
                $finish;
            end
        join_none

        // No valid output during reset or right after it
        repeat (2) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("out_valid was not low at %0t while reset was asserted", $time);
                tb_errs++;
            end
        end
        arst_n    = 1'b1;
        tri_valid = 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("out_valid was not low at %0t right after reset", $time);
            tb_errs++;
        end
        $display("test reset: %s", (tb_errs == 0) ? "ok" : "failed");

        for (int i = 0; i < tbl.size(); i++) begin
            apply_entry(i);
        end

        // With the next stage free everything in the chain comes out
        tri_valid = 1'b0;
        halt_n    = 1'b1;
        repeat (PIPE_DEPTH + 1) @(negedge clk);
        if (pending != 0) begin
            $display("%0d expected outputs never came out of the DUT", pending);
            tb_errs++;
        end

        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt + tb_errs);
        if (fail_cnt + tb_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/raster_fixed_pkg.sv
hw/raster_geom_pkg.sv
hw/bbox_extent.sv
hw/subsample_floor.sv
hw/screen_clip.sv
hw/bbox_stall_pipe.sv
hw/bbox_raster.sv
verif/bbox_checker.sv
verif/bbox_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the bounding-box testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module bbox_tb -f tb.f -o bbox_sim
./obj_dir/bbox_sim | tee sim.log

# Pass only when the testbench reported success
grep -q "Result: PASSED" sim.log
echo "Simulation passed"
